// File: all.f
hw/aes_dma_pkg.sv
hw/chunk_sequencer.sv
hw/bram_mover.sv
hw/cipher_lane.sv
hw/aes_dma_top.sv
sim/cipher_model.sv
sim/tb_aes_dma.sv

// File: hw/aes_dma_pkg.sv
`default_nettype none

package aes_dma_pkg;

    localparam int WORD_W      = 32;
    localparam int BLOCK_WORDS = 4;
    localparam int KEY_W       = 256;
    localparam int BLOCK_W     = 128;
    localparam int CHUNK_BYTES = 32;
    localparam int WORD_BYTES  = 4;

    ////////////////////
    // Job setup, sampled when start is seen in idle
    typedef struct packed {
        logic [31:0]      num_chunks;
        logic [31:0]      read_base;
        logic [31:0]      write_base;
        logic [KEY_W-1:0] key;
        logic             encdec;
    } job_cfg_t;

    // Single-word BRAM command
    typedef struct packed {
        logic              start_read;
        logic              start_write;
        logic [31:0]       addr;
        logic [WORD_W-1:0] wdata;
    } bram_req_t;

    ////////////////////
    // One AES engine lane
    typedef struct packed {
        logic               init;
        logic               next;
        logic               encdec;
        logic [KEY_W-1:0]   key;
        logic [BLOCK_W-1:0] block;
    } engine_req_t;

    typedef struct packed {
        logic               ready;
        logic [BLOCK_W-1:0] result;
    } engine_rsp_t;

    typedef enum logic [1:0] {
        MOVER_IDLE,
        MOVER_READ,
        MOVER_WRITE
    } mover_op_t;

endpackage

`default_nettype wire

// File: hw/aes_dma_top.sv
`timescale 1ns/100ps
`default_nettype none

module aes_dma_top #(
    parameter int ADDR_W = 32
) (
    input  wire logic                               aes_clk,
    input  wire logic                               aes_rst_n,
    input  wire logic                               start,
    input  wire aes_dma_pkg::job_cfg_t              cfg,
    output logic                                    complete,
    output aes_dma_pkg::bram_req_t                  bram,
    input  wire logic                               bram_complete,
    input  wire logic [aes_dma_pkg::WORD_W-1:0]     bram_rdata,
    output aes_dma_pkg::engine_req_t                eng0_req,
    output aes_dma_pkg::engine_req_t                eng1_req,
    input  wire aes_dma_pkg::engine_rsp_t           eng0_rsp,
    input  wire aes_dma_pkg::engine_rsp_t           eng1_rsp
);

    aes_dma_pkg::mover_op_t             mover_op;
    logic [ADDR_W-1:0]                  mover_addr;
    logic [aes_dma_pkg::BLOCK_W-1:0]    wblock;
    logic                               mover_done;
    logic                               key_init;
    logic [1:0]                         lane_go;
    logic [1:0]                         lane_load;
    logic [1:0]                         lane_done;
    logic [aes_dma_pkg::BLOCK_W-1:0]    lane_result0;
    logic [aes_dma_pkg::BLOCK_W-1:0]    lane_result1;
    logic [aes_dma_pkg::WORD_W-1:0]     rd_word;
    logic [1:0]                         rd_index;
    logic                               rd_strobe;

    chunk_sequencer #(
        .ADDR_W (ADDR_W)
    ) u_seq (
        .aes_clk       (aes_clk),
        .aes_rst_n     (aes_rst_n),
        .start         (start),
        .cfg           (cfg),
        .complete      (complete),
        .key_init      (key_init),
        .mover_op      (mover_op),
        .mover_addr    (mover_addr),
        .wblock        (wblock),
        .mover_done    (mover_done),
        .lane_go       (lane_go),
        .lane_load     (lane_load),
        .lane_done     (lane_done),
        .lane_result0  (lane_result0),
        .lane_result1  (lane_result1),
        .engines_ready ({eng1_rsp.ready, eng0_rsp.ready})
    );

    bram_mover #(
        .ADDR_W (ADDR_W)
    ) u_mover (
        .aes_clk       (aes_clk),
        .aes_rst_n     (aes_rst_n),
        .op            (mover_op),
        .base          (mover_addr),
        .wblock        (wblock),
        .bram          (bram),
        .bram_complete (bram_complete),
        .bram_rdata    (bram_rdata),
        .rd_word       (rd_word),
        .rd_index      (rd_index),
        .rd_strobe     (rd_strobe),
        .done          (mover_done)
    );

    // Read words land in whichever lane the sequencer is filling
    cipher_lane u_lane0 (
        .aes_clk    (aes_clk),
        .aes_rst_n  (aes_rst_n),
        .rd_word    (rd_word),
        .rd_index   (rd_index),
        .rd_load    (rd_strobe & lane_load[0]),
        .go         (lane_go[0]),
        .key_init   (key_init),
        .cfg_key    (cfg.key),
        .cfg_encdec (cfg.encdec),
        .req        (eng0_req),
        .rsp        (eng0_rsp),
        .done       (lane_done[0]),
        .result     (lane_result0)
    );

    cipher_lane u_lane1 (
        .aes_clk    (aes_clk),
        .aes_rst_n  (aes_rst_n),
        .rd_word    (rd_word),
        .rd_index   (rd_index),
        .rd_load    (rd_strobe & lane_load[1]),
        .go         (lane_go[1]),
        .key_init   (key_init),
        .cfg_key    (cfg.key),
        .cfg_encdec (cfg.encdec),
        .req        (eng1_req),
        .rsp        (eng1_rsp),
        .done       (lane_done[1]),
        .result     (lane_result1)
    );

endmodule

`default_nettype wire

// File: hw/bram_mover.sv
`timescale 1ns/100ps
`default_nettype none

module bram_mover #(
    parameter int ADDR_W = 32
) (
    input  wire logic                               aes_clk,
    input  wire logic                               aes_rst_n,
    input  wire aes_dma_pkg::mover_op_t             op,
    input  wire logic [ADDR_W-1:0]                  base,
    input  wire logic [aes_dma_pkg::BLOCK_W-1:0]    wblock,
    output aes_dma_pkg::bram_req_t                  bram,
    input  wire logic                               bram_complete,
    input  wire logic [aes_dma_pkg::WORD_W-1:0]     bram_rdata,
    output logic [aes_dma_pkg::WORD_W-1:0]          rd_word,
    output logic [1:0]                              rd_index,
    output logic                                    rd_strobe,
    output logic                                    done
);

    localparam int W = aes_dma_pkg::WORD_W;
    localparam int REST_W = aes_dma_pkg::BLOCK_W - W;

    typedef enum logic [1:0] {
        M_IDLE,
        M_XFER,
        M_GAP
    } mstate_t;

    mstate_t                mstate;
    aes_dma_pkg::mover_op_t op_q;
    logic                   start_q;
    logic [1:0]             idx_q;
    logic [ADDR_W-1:0]      addr_q;
    logic [W-1:0]           wdata_q;
    logic [REST_W-1:0]      wrest_q;

    always_comb begin
        bram.start_read  = start_q && (op_q == aes_dma_pkg::MOVER_READ);
        bram.start_write = start_q && (op_q == aes_dma_pkg::MOVER_WRITE);
        bram.addr        = 32'(addr_q);
        bram.wdata       = wdata_q;
    end

    ////////////////////
    // Word sequencing
    always_ff @(posedge aes_clk or negedge aes_rst_n) begin
        if (!aes_rst_n) begin
            mstate    <= M_IDLE;
            op_q      <= aes_dma_pkg::MOVER_IDLE;
            start_q   <= 1'b0;
            idx_q     <= '0;
            rd_strobe <= 1'b0;
            done      <= 1'b0;
        end else begin
            rd_strobe <= 1'b0;
            done      <= 1'b0;
            case (mstate)
                M_IDLE: begin
                    if (op != aes_dma_pkg::MOVER_IDLE) begin
                        op_q    <= op;
                        idx_q   <= '0;
                        start_q <= 1'b1;
                        mstate  <= M_XFER;
                    end
                end
                M_XFER: begin
                    if (bram_complete) begin
                        start_q   <= 1'b0;
                        rd_strobe <= (op_q == aes_dma_pkg::MOVER_READ);
                        if (idx_q == 2'(aes_dma_pkg::BLOCK_WORDS - 1)) begin
                            done   <= 1'b1;
                            mstate <= M_IDLE;
                        end else begin
                            mstate <= M_GAP;
                        end
                    end
                end
                M_GAP: begin
                    // One quiet cycle between words
                    start_q <= 1'b1;
                    idx_q   <= idx_q + 2'd1;
                    mstate  <= M_XFER;
                end
                default: mstate <= M_IDLE;
            endcase
        end
    end

    // Address, write data and captured read word
    always_ff @(posedge aes_clk) begin
        case (mstate)
            M_IDLE: begin
                addr_q  <= base;
                wdata_q <= wblock[aes_dma_pkg::BLOCK_W-1 -: W];
                wrest_q <= wblock[REST_W-1:0];
            end
            M_XFER: begin
                if (bram_complete) begin
                    rd_word  <= bram_rdata;
                    rd_index <= idx_q;
                end
            end
            M_GAP: begin
                addr_q  <= addr_q + ADDR_W'(aes_dma_pkg::WORD_BYTES);
                wdata_q <= wrest_q[REST_W-1 -: W];
                wrest_q <= wrest_q << W;
            end
            default: begin
            end
        endcase
    end

    // Op withdrawn in the done cycle, so the idle mover does not restart
    a_op_dropped: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
        done |-> op == aes_dma_pkg::MOVER_IDLE);

    // Request held steady until the memory answers
    a_req_hold: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
        start_q && !bram_complete |=> start_q && $stable(bram));

endmodule

`default_nettype wire

// File: hw/chunk_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

module chunk_sequencer #(
    parameter int ADDR_W = 32
) (
    input  wire logic                               aes_clk,
    input  wire logic                               aes_rst_n,
    input  wire logic                               start,
    input  wire aes_dma_pkg::job_cfg_t              cfg,
    output logic                                    complete,
    output logic                                    key_init,
    output aes_dma_pkg::mover_op_t                  mover_op,
    output logic [ADDR_W-1:0]                       mover_addr,
    output logic [aes_dma_pkg::BLOCK_W-1:0]         wblock,
    input  wire logic                               mover_done,
    output logic [1:0]                              lane_go,
    output logic [1:0]                              lane_load,
    input  wire logic [1:0]                         lane_done,
    input  wire logic [aes_dma_pkg::BLOCK_W-1:0]    lane_result0,
    input  wire logic [aes_dma_pkg::BLOCK_W-1:0]    lane_result1,
    input  wire logic [1:0]                         engines_ready
);

    localparam logic [ADDR_W-1:0] CHUNK_STEP = ADDR_W'(aes_dma_pkg::CHUNK_BYTES);
    localparam logic [ADDR_W-1:0] HALF_STEP  = ADDR_W'(aes_dma_pkg::CHUNK_BYTES / 2);

    typedef enum logic [3:0] {
        S_IDLE,
        S_KEY_INIT,
        S_KEY_WAIT,
        S_READ_A,
        S_GO_A,
        S_READ_B,
        S_GO_B,
        S_WRITE_A,
        S_WRITE_B,
        S_NEXT_CHUNK
    } state_t;

    state_t                         state;
    logic [31:0]                    chunks_left;
    logic [ADDR_W-1:0]              rd_ptr;
    logic [ADDR_W-1:0]              wr_ptr;
    logic [aes_dma_pkg::KEY_W-1:0]  key_q;
    logic                           key_loaded;
    logic                           new_key;

    assign new_key = !key_loaded || (cfg.key != key_q);

    ////////////////////
    // Decode toward mover and lanes
    always_comb begin
        key_init   = (state == S_KEY_INIT);
        lane_go    = {state == S_GO_B, state == S_GO_A};
        lane_load  = {state == S_READ_B, state == S_READ_A};
        mover_op   = aes_dma_pkg::MOVER_IDLE;
        mover_addr = rd_ptr;
        wblock     = lane_result0;
        // Op drops in the done cycle so the idle mover does not restart
        case (state)
            S_READ_A: begin
                if (!mover_done) begin
                    mover_op = aes_dma_pkg::MOVER_READ;
                end
            end
            S_READ_B: begin
                mover_addr = rd_ptr + HALF_STEP;
                if (!mover_done) begin
                    mover_op = aes_dma_pkg::MOVER_READ;
                end
            end
            S_WRITE_A: begin
                mover_addr = wr_ptr;
                if (lane_done[0] && !mover_done) begin
                    mover_op = aes_dma_pkg::MOVER_WRITE;
                end
            end
            S_WRITE_B: begin
                mover_addr = wr_ptr + HALF_STEP;
                wblock     = lane_result1;
                if (lane_done[1] && !mover_done) begin
                    mover_op = aes_dma_pkg::MOVER_WRITE;
                end
            end
            default: begin
            end
        endcase
    end

    ////////////////////
    // Job FSM
    always_ff @(posedge aes_clk or negedge aes_rst_n) begin
        if (!aes_rst_n) begin
            state       <= S_IDLE;
            chunks_left <= '0;
            rd_ptr      <= '0;
            wr_ptr      <= '0;
            key_loaded  <= 1'b0;
            complete    <= 1'b0;
        end else begin
            complete <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        chunks_left <= cfg.num_chunks;
                        rd_ptr      <= cfg.read_base[ADDR_W-1:0];
                        wr_ptr      <= cfg.write_base[ADDR_W-1:0];
                        if (cfg.num_chunks == '0) begin
                            complete <= 1'b1;
                        end else if (new_key) begin
                            key_loaded <= 1'b1;
                            state      <= S_KEY_INIT;
                        end else begin
                            state <= S_READ_A;
                        end
                    end
                end
                S_KEY_INIT: state <= S_KEY_WAIT;
                S_KEY_WAIT: begin
                    if (&engines_ready) begin
                        state <= S_READ_A;
                    end
                end
                S_READ_A: begin
                    if (mover_done) begin
                        state <= S_GO_A;
                    end
                end
                S_GO_A: state <= S_READ_B;
                S_READ_B: begin
                    if (mover_done) begin
                        state <= S_GO_B;
                    end
                end
                S_GO_B: state <= S_WRITE_A;
                S_WRITE_A: begin
                    if (mover_done) begin
                        state <= S_WRITE_B;
                    end
                end
                S_WRITE_B: begin
                    if (mover_done) begin
                        state <= S_NEXT_CHUNK;
                    end
                end
                S_NEXT_CHUNK: begin
                    if (chunks_left == 32'd1) begin
                        complete <= 1'b1;
                        state    <= S_IDLE;
                    end else begin
                        chunks_left <= chunks_left - 32'd1;
                        rd_ptr      <= rd_ptr + CHUNK_STEP;
                        wr_ptr      <= wr_ptr + CHUNK_STEP;
                        state       <= S_READ_A;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Key of the last job that went through init
    always_ff @(posedge aes_clk) begin
        if (state == S_IDLE && start && cfg.num_chunks != '0) begin
            key_q <= cfg.key;
        end
    end

    // A lane is restarted only after it reported its result
    for (genvar n = 0; n < 2; n++) begin : g_go_check
        a_go_after_done: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
            lane_go[n] |=> !lane_go[n] until lane_done[n]);
    end

endmodule

`default_nettype wire

// File: hw/cipher_lane.sv
`timescale 1ns/100ps
`default_nettype none

module cipher_lane (
    input  wire logic                               aes_clk,
    input  wire logic                               aes_rst_n,
    input  wire logic [aes_dma_pkg::WORD_W-1:0]     rd_word,
    input  wire logic [1:0]                         rd_index,
    input  wire logic                               rd_load,
    input  wire logic                               go,
    input  wire logic                               key_init,
    input  wire logic [aes_dma_pkg::KEY_W-1:0]      cfg_key,
    input  wire logic                               cfg_encdec,
    output aes_dma_pkg::engine_req_t                req,
    input  wire aes_dma_pkg::engine_rsp_t           rsp,
    output logic                                    done,
    output logic [aes_dma_pkg::BLOCK_W-1:0]         result
);

    // Word 0 is the most significant
    logic [0:aes_dma_pkg::BLOCK_WORDS-1][aes_dma_pkg::WORD_W-1:0] block_q;
    logic busy_q;
    logic hold_q;
    logic capture;

    always_comb begin
        req.init   = key_init;
        req.next   = go;
        req.encdec = cfg_encdec;
        req.key    = cfg_key;
        req.block  = block_q;
    end

    // Ready is not trusted in the first cycle after next
    assign capture = busy_q && !hold_q && rsp.ready;

    ////////////////////
    // Block assembly and result capture
    always_ff @(posedge aes_clk) begin
        if (rd_load) begin
            block_q[rd_index] <= rd_word;
        end
        if (capture) begin
            result <= rsp.result;
        end
    end

    always_ff @(posedge aes_clk or negedge aes_rst_n) begin
        if (!aes_rst_n) begin
            busy_q <= 1'b0;
            hold_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            hold_q <= go;
            if (go) begin
                busy_q <= 1'b1;
                done   <= 1'b0;
            end else if (capture) begin
                busy_q <= 1'b0;
                done   <= 1'b1;
            end
        end
    end

    a_next_when_ready: assert property (@(posedge aes_clk) disable iff (!aes_rst_n)
        req.next |-> rsp.ready);

endmodule

`default_nettype wire

// File: sim/cipher_model.sv
`timescale 1ns/100ps
`default_nettype none

module cipher_model #(
    parameter int INIT_CYCLES = 20,
    parameter int NEXT_CYCLES = 12
) (
    input  wire logic                       aes_clk,
    input  wire logic                       aes_rst_n,
    input  wire aes_dma_pkg::engine_req_t   req,
    output aes_dma_pkg::engine_rsp_t        rsp,
    output logic [31:0]                     init_count
);

    logic [31:0] busy_cnt;

    // encdec high selects the upper key half (encrypt)
    always_ff @(posedge aes_clk or negedge aes_rst_n) begin
        if (!aes_rst_n) begin
            rsp.ready  <= 1'b1;
            rsp.result <= '0;
            busy_cnt   <= '0;
            init_count <= '0;
        end else begin
            if (req.init) begin
                init_count <= init_count + 32'd1;
            end
            if (rsp.ready) begin
                if (req.init) begin
                    rsp.ready <= 1'b0;
                    busy_cnt  <= 32'(INIT_CYCLES - 1);
                end else if (req.next) begin
                    rsp.ready  <= 1'b0;
                    busy_cnt   <= 32'(NEXT_CYCLES - 1);
                    rsp.result <= req.block ^ (req.encdec ? req.key[255:128] : req.key[127:0]);
                end
            end else if (busy_cnt == '0) begin
                rsp.ready <= 1'b1;
            end else begin
                busy_cnt <= busy_cnt - 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: sim/tb_aes_dma.sv
`timescale 1ns/100ps
`default_nettype none

module tb_aes_dma;

    localparam int MEM_WORDS = 1024;
    localparam int TIMEOUT   = 5000;
    localparam int NUM_ROWS  = 6;

    typedef struct packed {
        aes_dma_pkg::job_cfg_t cfg;
        logic [31:0]           inits;
    } row_t;

    logic                       aes_clk;
    logic                       aes_rst_n;
    logic                       start;
    aes_dma_pkg::job_cfg_t      cfg;
    logic                       complete;
    aes_dma_pkg::bram_req_t     bram;
    logic                       bram_complete;
    logic [31:0]                bram_rdata;
    aes_dma_pkg::engine_req_t   eng0_req;
    aes_dma_pkg::engine_req_t   eng1_req;
    aes_dma_pkg::engine_rsp_t   eng0_rsp;
    aes_dma_pkg::engine_rsp_t   eng1_rsp;
    logic [31:0]                init_count0;
    logic [31:0]                init_count1;

    logic [31:0]    mem [MEM_WORDS];
    logic [31:0]    orig [MEM_WORDS];
    logic [31:0]    exp_mem [MEM_WORDS];
    row_t           rows [NUM_ROWS];
    logic [31:0]    lcg_state;
    logic [31:0]    win_lo;
    logic [31:0]    win_hi;
    logic           bram_busy;
    logic [31:0]    bram_wait;
    int             access_count;
    int             complete_count;
    int             fail_count;

    aes_dma_top #(
        .ADDR_W (32)
    ) uut (
        .aes_clk       (aes_clk),
        .aes_rst_n     (aes_rst_n),
        .start         (start),
        .cfg           (cfg),
        .complete      (complete),
        .bram          (bram),
        .bram_complete (bram_complete),
        .bram_rdata    (bram_rdata),
        .eng0_req      (eng0_req),
        .eng1_req      (eng1_req),
        .eng0_rsp      (eng0_rsp),
        .eng1_rsp      (eng1_rsp)
    );

    cipher_model u_eng0 (
        .aes_clk    (aes_clk),
        .aes_rst_n  (aes_rst_n),
        .req        (eng0_req),
        .rsp        (eng0_rsp),
        .init_count (init_count0)
    );

    cipher_model u_eng1 (
        .aes_clk    (aes_clk),
        .aes_rst_n  (aes_rst_n),
        .req        (eng1_req),
        .rsp        (eng1_rsp),
        .init_count (init_count1)
    );

    initial aes_clk = 1'b0;
    always #4 aes_clk = ~aes_clk;

    function logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // Word i of the key half, word 0 most significant
    function automatic logic [31:0] key_word(input logic [255:0] key, input logic ed,
                                             input int i);
        logic [127:0] half;
        half = ed ? key[255:128] : key[127:0];
        return half[127 - 32 * i -: 32];
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s = %h, expected %h", $time, name, got, exp);
            fail_count++;
            $display("Errors found");
            $fatal(1, "stopped at first error");
        end
    endtask

    ////////////////////
    // BRAM model, answers after 1 to 4 cycles
    always @(posedge aes_clk) begin
        if (bram_complete) begin
            bram_complete <= 1'b0;
            bram_busy     <= 1'b0;
        end else if (bram_busy) begin
            if (bram_wait == '0) begin
                bram_complete <= 1'b1;
                access_count  <= access_count + 1;
                if (bram.start_write) begin
                    check("write inside window",
                          32'(bram.addr >= win_lo && bram.addr < win_hi), 32'd1);
                    mem[bram.addr[11:2]] <= bram.wdata;
                end else begin
                    bram_rdata <= mem[bram.addr[11:2]];
                end
            end else begin
                bram_wait <= bram_wait - 32'd1;
            end
        end else if (bram.start_read || bram.start_write) begin
            bram_busy <= 1'b1;
            bram_wait <= (lcg_next() >> 16) % 4;
        end
    end

    always @(posedge aes_clk) begin
        if (complete) begin
            complete_count <= complete_count + 1;
        end
    end

    task automatic set_row(input int r, input logic [31:0] n, input logic [31:0] rb,
                           input logic [31:0] wb, input logic [255:0] key,
                           input logic ed, input logic [31:0] inits);
        rows[r].cfg.num_chunks = n;
        rows[r].cfg.read_base  = rb;
        rows[r].cfg.write_base = wb;
        rows[r].cfg.key        = key;
        rows[r].cfg.encdec     = ed;
        rows[r].inits          = inits;
    endtask

    task automatic run_row(input int r);
        aes_dma_pkg::job_cfg_t c;
        int     i;
        int     ch;
        int     k;
        int     n;
        int     ri;
        int     wi;
        int     inits0;
        int     inits1;
        int     acc0;
        int     cmp0;
        logic   got;
        c      = rows[r].cfg;
        win_lo = c.write_base;
        win_hi = c.write_base + c.num_chunks * 32;
        for (i = 0; i < MEM_WORDS; i++) begin
            exp_mem[i] = mem[i];
        end
        // Block A at +0, block B at +16 of each chunk
        for (ch = 0; ch < c.num_chunks; ch++) begin
            for (k = 0; k < 8; k++) begin
                ri = (c.read_base + ch * 32 + k * 4) >> 2;
                wi = (c.write_base + ch * 32 + k * 4) >> 2;
                exp_mem[wi] = mem[ri] ^ key_word(c.key, c.encdec, k % 4);
            end
        end
        inits0 = init_count0;
        inits1 = init_count1;
        acc0   = access_count;
        cmp0   = complete_count;
        @(posedge aes_clk);
        cfg   <= c;
        start <= 1'b1;
        @(posedge aes_clk);
        start <= 1'b0;
        got = 1'b0;
        for (n = 0; n < TIMEOUT && !got; n++) begin
            @(negedge aes_clk);
            got = complete;
        end
        if (!got) begin
            $display("Timeout: job of row %0d never signalled complete", r);
            fail_count++;
            $display("Errors found");
            $fatal(1, "stopped on timeout");
        end
        @(negedge aes_clk);
        check("complete after pulse", 32'(complete), 32'd0);
        repeat (4) @(negedge aes_clk);
        check("complete pulses", complete_count - cmp0, 32'd1);
        check("engine 0 init pulses", init_count0 - inits0, rows[r].inits);
        check("engine 1 init pulses", init_count1 - inits1, rows[r].inits);
        check("bram accesses", access_count - acc0, c.num_chunks * 16);
        for (i = 0; i < MEM_WORDS; i++) begin
            check($sformatf("mem[0x%0h]", i * 4), mem[i], exp_mem[i]);
        end
    endtask

    initial begin
        int i;
        aes_rst_n      = 1'b0;
        start          = 1'b0;
        cfg            = '0;
        bram_complete  = 1'b0;
        bram_rdata     = '0;
        bram_busy      = 1'b0;
        bram_wait      = '0;
        access_count   = 0;
        complete_count = 0;
        fail_count     = 0;
        win_lo         = '0;
        win_hi         = '0;
        lcg_state      = 32'd27;
        for (i = 0; i < MEM_WORDS; i++) begin
            orig[i] = lcg_next() ^ 32'(i);
            mem[i]  = orig[i];
        end
        // Chunks, read base, write base, key, encdec, expected inits
        set_row(0, 3, 32'h000, 32'h400,
                {128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0,
                 128'h11223344_55667788_99aabbcc_ddeeff00}, 1'b1, 1);
        set_row(1, 2, 32'h100, 32'h500,
                {128'h0f1e2d3c_4b5a6978_8796a5b4_c3d2e1f0,
                 128'h11223344_55667788_99aabbcc_ddeeff00}, 1'b0, 0);
        set_row(2, 0, 32'h200, 32'h600,
                {128'h31415926_53589793_23846264_33832795,
                 128'h27182818_28459045_23536028_74713526}, 1'b1, 0);
        // Equal halves, so decrypt undoes encrypt
        set_row(3, 4, 32'h200, 32'h600,
                {128'h2b7e1516_28aed2a6_abf71588_09cf4f3c,
                 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c}, 1'b1, 1);
        set_row(4, 4, 32'h600, 32'h800,
                {128'h2b7e1516_28aed2a6_abf71588_09cf4f3c,
                 128'h2b7e1516_28aed2a6_abf71588_09cf4f3c}, 1'b0, 0);
        set_row(5, 1, 32'h080, 32'h700,
                {128'h31415926_53589793_23846264_33832795,
                 128'h27182818_28459045_23536028_74713526}, 1'b1, 1);
        repeat (3) @(posedge aes_clk);
        aes_rst_n <= 1'b1;
        for (i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        for (i = 0; i < 32; i++) begin
            check($sformatf("round trip word %0d", i), mem[(32'h800 >> 2) + i],
                  orig[(32'h200 >> 2) + i]);
        end
        if (fail_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
